//--- hdl/bridge_defs.svh
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

// Width of the AXI id field carried from the AR channel to the R channel
`define BRIDGE_ID_W 4

// Address width, the same on the AXI and the AXI-Lite side
`define BRIDGE_ADDR_W 32

// Data width, the same on both sides because the bridge does no width conversion
`define BRIDGE_DATA_W 32

// Width of the AXI burst length field (beats minus one)
`define BRIDGE_LEN_W 8

// Low address bits that a burst may change, since a burst never crosses 4 KB
`define BRIDGE_PAGE_W 12

// Default number of read bursts that may be outstanding at the slave
// Two is enough to keep a slave that answers every cycle busy
`define BRIDGE_MAX_R_XACT 2

`endif

//--- hdl/axi_pkg.sv
package axi_pkg;

    // Burst type as encoded on ARBURST
    // The encoding 2'b11 is reserved by the protocol
    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10
    } burst_t;

    // Protection attributes: privileged, non-secure and instruction bits
    typedef logic [2:0] prot_t;

    // Read response code, returned per beat on the R channel
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } resp_t;

    // Beat size as log2 of the number of bytes in one beat
    typedef logic [2:0] size_t;

endpackage

//--- hdl/bridge_pkg.sv
`include "bridge_defs.svh"

package bridge_pkg;

    // One queue entry, written on the AR side when a burst is accepted
    // The R side needs the id to return it and the length to place last
    typedef struct packed {
        logic [`BRIDGE_ID_W-1:0]  id;
        logic [`BRIDGE_LEN_W-1:0] len;
    } xact_t;

endpackage

//--- hdl/xact_if.sv
`timescale 1ns/100ps

// Carries one burst record with a valid/ready handshake
// A record moves on a rising clock edge where valid and ready are both high
interface xact_if;

    logic              valid;
    logic              ready;
    bridge_pkg::xact_t xact;

    // The side that offers records
    modport producer (
        output valid,
        output xact,
        input  ready
    );

    // The side that takes records
    modport consumer (
        input  valid,
        input  xact,
        output ready
    );

endinterface

//--- hdl/ar_splitter.sv
`timescale 1ns/100ps
`include "bridge_defs.svh"

// Turns one AXI read burst into one AXI-Lite read per beat
// The first beat goes straight through from the master, the rest come from local registers
module ar_splitter (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic [`BRIDGE_ADDR_W-1:0] axi_ar_addr,
    input  logic [`BRIDGE_ID_W-1:0]   axi_ar_id,
    input  logic [`BRIDGE_LEN_W-1:0]  axi_ar_len,
    input  axi_pkg::size_t            axi_ar_size,
    input  axi_pkg::burst_t           axi_ar_burst,
    input  axi_pkg::prot_t            axi_ar_prot,
    input  logic                      axi_ar_valid,
    output logic                      axi_ar_ready,
    output logic [`BRIDGE_ADDR_W-1:0] lite_ar_addr,
    output axi_pkg::prot_t            lite_ar_prot,
    output logic                      lite_ar_valid,
    input  logic                      lite_ar_ready,
    xact_if.producer                  q_in
);

    localparam int page_w = `BRIDGE_PAGE_W;

    typedef logic [page_w-1:0] page_t;

    // Next address within the 4 KB page
    // FIXED keeps it, INCR aligns down and steps, WRAP steps inside the wrap block
    function automatic page_t increment(
        input page_t           addr,
        input axi_pkg::size_t  size,
        input logic [3:0]      wrap_len,
        input axi_pkg::burst_t burst
    );
        page_t step;
        page_t mask;
        step = page_t'(1) << size;
        case (burst)
            axi_pkg::burst_incr: begin
                mask      = step - 1'b1;
                increment = (addr & ~mask) + step;
            end
            axi_pkg::burst_wrap: begin
                // Wrap lengths are 1, 3, 7 or 15, which already form a mask
                mask      = page_t'(wrap_len) << size;
                increment = ((addr + step) & mask) | (addr & ~mask);
            end
            default: begin
                // FIXED and the reserved encoding both keep the address
                increment = addr;
            end
        endcase
    endfunction

    // High while the remaining beats of a burst are being issued
    logic                      in_burst;
    // Burst attributes captured when the master's request is accepted
    axi_pkg::size_t            size_q;
    axi_pkg::burst_t           burst_q;
    axi_pkg::prot_t            prot_q;
    logic [3:0]                wrap_len_q;
    // Address of the beat sent last, and the one to send now
    logic [`BRIDGE_ADDR_W-1:0] addr_q;
    logic [`BRIDGE_ADDR_W-1:0] addr_next;
    // Beats still to be issued after the one sent last
    logic [`BRIDGE_LEN_W-1:0]  len_q;
    logic [`BRIDGE_LEN_W-1:0]  len_next;
    logic                      ar_accept;

    // Only the low page bits move; the upper bits stay with the burst
    assign addr_next = {addr_q[`BRIDGE_ADDR_W-1:page_w],
                        increment(addr_q[page_w-1:0], size_q, wrap_len_q, burst_q)};
    assign len_next  = len_q - 1'b1;

    assign ar_accept = axi_ar_valid && axi_ar_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            in_burst <= 1'b0;
        end else if (in_burst) begin
            // Leave once the final beat has been taken by the slave
            if (lite_ar_ready && len_next == '0) begin
                in_burst <= 1'b0;
            end
        end else if (ar_accept && axi_ar_len != '0) begin
            in_burst <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (in_burst) begin
            if (lite_ar_ready) begin
                addr_q <= addr_next;
                len_q  <= len_next;
            end
        end else if (ar_accept) begin
            size_q     <= axi_ar_size;
            burst_q    <= axi_ar_burst;
            prot_q     <= axi_ar_prot;
            wrap_len_q <= axi_ar_len[3:0];
            addr_q     <= axi_ar_addr;
            len_q      <= axi_ar_len;
        end
    end

    // When idle the master talks to the slave directly, as long as the queue has room
    assign lite_ar_addr  = in_burst ? addr_next : axi_ar_addr;
    assign lite_ar_prot  = in_burst ? prot_q : axi_ar_prot;
    assign lite_ar_valid = in_burst || (axi_ar_valid && q_in.ready);
    assign axi_ar_ready  = !in_burst && lite_ar_ready && q_in.ready;

    // The record goes into the queue in the cycle the master's request is accepted
    assign q_in.valid = !in_burst && axi_ar_valid && lite_ar_ready;
    assign q_in.xact  = bridge_pkg::xact_t'{id: axi_ar_id, len: axi_ar_len};

endmodule

//--- hdl/xact_queue.sv
`timescale 1ns/100ps
`include "bridge_defs.svh"

// Circular buffer of burst records between the AR side and the R side
module xact_queue #(
    parameter int depth = `BRIDGE_MAX_R_XACT
) (
    input  logic     clk,
    input  logic     rstn,
    xact_if.consumer q_in,
    xact_if.producer q_out
);

    // A depth of one still needs a one bit pointer
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    bridge_pkg::xact_t mem [depth];
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [cnt_w-1:0]  count;
    logic              push;
    logic              pop;

    // Pointers wrap at depth, which need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            next_ptr = '0;
        end else begin
            next_ptr = ptr + 1'b1;
        end
    endfunction

    assign q_in.ready  = count != cnt_w'(depth);
    assign q_out.valid = count != '0;
    assign q_out.xact  = mem[rd_ptr];

    assign push = q_in.valid && q_in.ready;
    assign pop  = q_out.valid && q_out.ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= q_in.xact;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Push and pop together leave the count as it is
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hdl/r_tagger.sv
`timescale 1ns/100ps
`include "bridge_defs.svh"

// Rebuilds the AXI id and last on the read data coming back from the Lite slave
// Data, response and handshake go through untouched
module r_tagger (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic [`BRIDGE_DATA_W-1:0] lite_r_data,
    input  axi_pkg::resp_t            lite_r_resp,
    input  logic                      lite_r_valid,
    output logic                      lite_r_ready,
    output logic [`BRIDGE_ID_W-1:0]   axi_r_id,
    output logic [`BRIDGE_DATA_W-1:0] axi_r_data,
    output axi_pkg::resp_t            axi_r_resp,
    output logic                      axi_r_last,
    output logic                      axi_r_valid,
    input  logic                      axi_r_ready,
    xact_if.consumer                  q_out
);

    // High after the first beat of a multi-beat burst until its last beat
    logic                     in_burst;
    // Id and remaining beats latched from the head record on the first beat
    logic [`BRIDGE_ID_W-1:0]  id_q;
    logic [`BRIDGE_LEN_W-1:0] len_q;
    logic [`BRIDGE_LEN_W-1:0] len_next;
    logic                     beat;
    logic                     first_beat;

    assign beat       = lite_r_valid && axi_r_ready;
    assign first_beat = !in_burst && q_out.valid && beat;
    assign len_next   = len_q - 1'b1;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            in_burst <= 1'b0;
        end else if (in_burst) begin
            if (beat && len_next == '0) begin
                in_burst <= 1'b0;
            end
        end else if (first_beat && q_out.xact.len != '0) begin
            // Single beat bursts never enter this state
            in_burst <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (first_beat) begin
            id_q  <= q_out.xact.id;
            len_q <= q_out.xact.len;
        end else if (in_burst && beat) begin
            len_q <= len_next;
        end
    end

    // The record leaves the queue once, on the first accepted beat of its burst
    assign q_out.ready = first_beat;

    assign axi_r_id     = in_burst ? id_q : q_out.xact.id;
    assign axi_r_last   = (in_burst ? len_next : q_out.xact.len) == '0;
    assign axi_r_data   = lite_r_data;
    assign axi_r_resp   = lite_r_resp;
    assign axi_r_valid  = lite_r_valid;
    assign lite_r_ready = axi_r_ready;

endmodule

//--- hdl/axi_rd_to_lite.sv
`timescale 1ns/100ps
`include "bridge_defs.svh"

// Read bridge from an AXI master to an AXI-Lite slave
// max_r_xact sets how many bursts may wait for their data at once
module axi_rd_to_lite #(
    parameter int max_r_xact = `BRIDGE_MAX_R_XACT
) (
    input  logic                      clk,
    input  logic                      rstn,
    // AXI read address channel from the master
    input  logic [`BRIDGE_ADDR_W-1:0] axi_ar_addr,
    input  logic [`BRIDGE_ID_W-1:0]   axi_ar_id,
    input  logic [`BRIDGE_LEN_W-1:0]  axi_ar_len,
    input  axi_pkg::size_t            axi_ar_size,
    input  axi_pkg::burst_t           axi_ar_burst,
    input  axi_pkg::prot_t            axi_ar_prot,
    input  logic                      axi_ar_valid,
    output logic                      axi_ar_ready,
    // AXI-Lite read address channel to the slave
    output logic [`BRIDGE_ADDR_W-1:0] lite_ar_addr,
    output axi_pkg::prot_t            lite_ar_prot,
    output logic                      lite_ar_valid,
    input  logic                      lite_ar_ready,
    // AXI-Lite read data channel from the slave
    input  logic [`BRIDGE_DATA_W-1:0] lite_r_data,
    input  axi_pkg::resp_t            lite_r_resp,
    input  logic                      lite_r_valid,
    output logic                      lite_r_ready,
    // AXI read data channel back to the master
    output logic [`BRIDGE_ID_W-1:0]   axi_r_id,
    output logic [`BRIDGE_DATA_W-1:0] axi_r_data,
    output axi_pkg::resp_t            axi_r_resp,
    output logic                      axi_r_last,
    output logic                      axi_r_valid,
    input  logic                      axi_r_ready
);

    // Records from the splitter into the queue, and from the queue to the tagger
    xact_if q_in ();
    xact_if q_out ();

    ar_splitter u_ar_splitter (
        .clk           (clk),
        .rstn          (rstn),
        .axi_ar_addr   (axi_ar_addr),
        .axi_ar_id     (axi_ar_id),
        .axi_ar_len    (axi_ar_len),
        .axi_ar_size   (axi_ar_size),
        .axi_ar_burst  (axi_ar_burst),
        .axi_ar_prot   (axi_ar_prot),
        .axi_ar_valid  (axi_ar_valid),
        .axi_ar_ready  (axi_ar_ready),
        .lite_ar_addr  (lite_ar_addr),
        .lite_ar_prot  (lite_ar_prot),
        .lite_ar_valid (lite_ar_valid),
        .lite_ar_ready (lite_ar_ready),
        .q_in          (q_in.producer)
    );

    xact_queue #(
        .depth (max_r_xact)
    ) u_xact_queue (
        .clk   (clk),
        .rstn  (rstn),
        .q_in  (q_in.consumer),
        .q_out (q_out.producer)
    );

    r_tagger u_r_tagger (
        .clk          (clk),
        .rstn         (rstn),
        .lite_r_data  (lite_r_data),
        .lite_r_resp  (lite_r_resp),
        .lite_r_valid (lite_r_valid),
        .lite_r_ready (lite_r_ready),
        .axi_r_id     (axi_r_id),
        .axi_r_data   (axi_r_data),
        .axi_r_resp   (axi_r_resp),
        .axi_r_last   (axi_r_last),
        .axi_r_valid  (axi_r_valid),
        .axi_r_ready  (axi_r_ready),
        .q_out        (q_out.consumer)
    );

endmodule

//--- test/axi_rd_to_lite_chk.sv
`timescale 1ns/100ps
`include "bridge_defs.svh"

// Protocol checks on the outside ports of the read bridge, bound into the top level
module axi_rd_to_lite_chk (
    input logic                      clk,
    input logic                      rstn,
    input logic [`BRIDGE_ADDR_W-1:0] axi_ar_addr,
    input logic                      axi_ar_valid,
    input logic                      axi_ar_ready,
    input logic                      lite_ar_valid,
    input logic                      lite_ar_ready,
    input logic                      lite_r_valid,
    input logic                      lite_r_ready
);

    // Lite reads that the slave has accepted and not yet answered
    logic [7:0] outstanding;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + 8'(lite_ar_valid && lite_ar_ready)
                                       - 8'(lite_r_valid && lite_r_ready);
        end
    end

    // The slave may only answer a read that it was sent
    a_r_has_request: assert property (@(posedge clk) disable iff (!rstn)
        lite_r_valid |-> outstanding != '0)
        else $error("lite R valid with no read outstanding");

    // The master keeps its request and address steady until the bridge takes it
    a_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
        axi_ar_valid && !axi_ar_ready |=> axi_ar_valid && $stable(axi_ar_addr))
        else $error("AXI AR request dropped or changed before acceptance");

    // The bridge never withdraws a Lite read request before the slave takes it
    a_lite_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
        lite_ar_valid && !lite_ar_ready |=> lite_ar_valid)
        else $error("Lite AR valid dropped before acceptance");

endmodule

//--- test/tb_axi_rd_to_lite.sv
`timescale 1ns/100ps
`include "bridge_defs.svh"

// Drives AXI read bursts into the bridge and models the AXI-Lite slave behind it
module tb_axi_rd_to_lite;

    localparam int page_w = `BRIDGE_PAGE_W;

    // A burst as the master issued it, held until its last beat has come back
    typedef struct packed {
        logic [`BRIDGE_ID_W-1:0]   id;
        logic [`BRIDGE_ADDR_W-1:0] addr;
        logic [`BRIDGE_LEN_W-1:0]  len;
        axi_pkg::size_t            size;
        axi_pkg::burst_t           burst;
    } burst_rec_t;

    logic                      clk = 1'b0;
    logic                      rstn = 1'b0;
    logic [`BRIDGE_ADDR_W-1:0] axi_ar_addr = '0;
    logic [`BRIDGE_ID_W-1:0]   axi_ar_id = '0;
    logic [`BRIDGE_LEN_W-1:0]  axi_ar_len = '0;
    axi_pkg::size_t            axi_ar_size = '0;
    axi_pkg::burst_t           axi_ar_burst = axi_pkg::burst_incr;
    axi_pkg::prot_t            axi_ar_prot = '0;
    logic                      axi_ar_valid = 1'b0;
    logic                      axi_ar_ready;
    logic [`BRIDGE_ADDR_W-1:0] lite_ar_addr;
    axi_pkg::prot_t            lite_ar_prot;
    logic                      lite_ar_valid;
    logic                      lite_ar_ready = 1'b0;
    logic [`BRIDGE_DATA_W-1:0] lite_r_data = '0;
    axi_pkg::resp_t            lite_r_resp = axi_pkg::resp_okay;
    logic                      lite_r_valid = 1'b0;
    logic                      lite_r_ready;
    logic [`BRIDGE_ID_W-1:0]   axi_r_id;
    logic [`BRIDGE_DATA_W-1:0] axi_r_data;
    axi_pkg::resp_t            axi_r_resp;
    logic                      axi_r_last;
    logic                      axi_r_valid;
    logic                      axi_r_ready = 1'b0;

    integer                    seed = 17508;
    // When set, the slave and the master stall their ready signals at random
    logic                      stall_en = 1'b0;
    string                     test_name = "reset";
    int                        errors = 0;
    int                        checks_done = 0;
    int                        beats_checked = 0;
    int                        tests_run = 0;
    int                        beats_at_start = 0;
    int                        errors_at_start = 0;
    bit                        timed_out = 1'b0;
    // Bursts waiting for their R beats, and the beat index within the head one
    burst_rec_t                exp_q[$];
    int                        beat_idx = 0;
    // Protection each Lite read is expected to carry, one entry per beat
    axi_pkg::prot_t            prot_q[$];
    // Addresses the slave has accepted and not yet answered
    logic [`BRIDGE_ADDR_W-1:0] rsp_q[$];
    int                        r_wait = 0;

    always #2 clk = ~clk;

    axi_rd_to_lite #(.max_r_xact(2)) u_axi_rd_to_lite (.*);

    bind axi_rd_to_lite axi_rd_to_lite_chk u_axi_rd_to_lite_chk (
        .clk           (clk),
        .rstn          (rstn),
        .axi_ar_addr   (axi_ar_addr),
        .axi_ar_valid  (axi_ar_valid),
        .axi_ar_ready  (axi_ar_ready),
        .lite_ar_valid (lite_ar_valid),
        .lite_ar_ready (lite_ar_ready),
        .lite_r_valid  (lite_r_valid),
        .lite_r_ready  (lite_r_ready)
    );

    // Address of beat idx of a burst, worked out in closed form from the burst rules
    // Only the low page bits move and the upper bits stay with the burst
    function automatic logic [`BRIDGE_ADDR_W-1:0] expected_beat(
        input logic [`BRIDGE_ADDR_W-1:0] addr,
        input axi_pkg::size_t            size,
        input logic [`BRIDGE_LEN_W-1:0]  len,
        input axi_pkg::burst_t           burst,
        input int                        idx
    );
        logic [page_w-1:0] low;
        logic [page_w-1:0] step;
        logic [page_w-1:0] mask;
        low  = addr[page_w-1:0];
        step = page_w'(1) << size;
        mask = page_w'(len[3:0]) << size;
        if (burst == axi_pkg::burst_incr && idx != 0) begin
            // Later beats sit on aligned steps counted from the aligned start
            low = (low & ~(step - page_w'(1))) + step * page_w'(idx);
        end else if (burst == axi_pkg::burst_wrap) begin
            low = ((low + step * page_w'(idx)) & mask) | (low & ~mask);
        end
        expected_beat = {addr[`BRIDGE_ADDR_W-1:page_w], low};
    endfunction

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks_done++;
        if (expected !== actual) begin
            errors++;
            $display("MISMATCH test %s %s: expected %h, actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    // Lite slave model that takes addresses and answers them in order after a random pause
    always begin : lite_slave
        bit ar_fire;
        bit r_fire;
        @(negedge clk);
        ar_fire = lite_ar_valid && lite_ar_ready;
        r_fire  = lite_r_valid && lite_r_ready;
        if (ar_fire) begin
            rsp_q.push_back(lite_ar_addr);
            if (prot_q.size() == 0) begin
                errors++;
                $display("ERROR test %s: Lite read issued with no beat expected", test_name);
            end else begin
                check("lite prot", 32'(prot_q.pop_front()), 32'(lite_ar_prot));
            end
        end
        if (r_fire) begin
            void'(rsp_q.pop_front());
        end
        @(posedge clk);
        #1;
        lite_ar_ready = stall_en ? (($random(seed) & 3) != 0) : 1'b1;
        if (r_fire) begin
            lite_r_valid = 1'b0;
        end
        if (!lite_r_valid && rsp_q.size() != 0) begin
            if (r_wait == 0) begin
                lite_r_data  = rsp_q[0] ^ 32'h5a5a_0000;
                lite_r_resp  = rsp_q[0][11] ? axi_pkg::resp_slverr : axi_pkg::resp_okay;
                lite_r_valid = 1'b1;
                r_wait       = $random(seed) & 3;
            end else begin
                r_wait--;
            end
        end
    end

    // Compares every accepted R beat with the head burst of the expected queue
    always begin : r_compare
        burst_rec_t                rec;
        logic [`BRIDGE_ADDR_W-1:0] exp_addr;
        axi_pkg::resp_t            exp_resp;
        bit                        is_last;
        @(negedge clk);
        if (rstn && axi_r_valid && axi_r_ready) begin
            // Every beat the DUT hands over counts, expected or not
            beats_checked++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("ERROR test %s: R beat arrived with no burst outstanding", test_name);
            end else begin
                rec      = exp_q[0];
                exp_addr = expected_beat(rec.addr, rec.size, rec.len, rec.burst, beat_idx);
                exp_resp = exp_addr[11] ? axi_pkg::resp_slverr : axi_pkg::resp_okay;
                is_last  = beat_idx == int'(rec.len);
                check($sformatf("beat %0d id", beat_idx), 32'(rec.id), 32'(axi_r_id));
                check($sformatf("beat %0d data", beat_idx), exp_addr ^ 32'h5a5a_0000,
                      axi_r_data);
                check($sformatf("beat %0d resp", beat_idx), 32'(exp_resp), 32'(axi_r_resp));
                check($sformatf("beat %0d last", beat_idx), 32'(is_last), 32'(axi_r_last));
                if (is_last) begin
                    void'(exp_q.pop_front());
                    beat_idx = 0;
                end else begin
                    beat_idx++;
                end
            end
        end
        @(posedge clk);
        #1;
        axi_r_ready = stall_en ? (($random(seed) & 3) != 0) : 1'b1;
    end

    task automatic start_test(input string name, input logic stall);
        test_name       = name;
        stall_en        = stall;
        beats_at_start  = beats_checked;
        errors_at_start = errors;
    endtask

    // Offers one burst on AR and holds it until the bridge accepts it
    task automatic send_burst(input logic [`BRIDGE_ID_W-1:0] id,
                              input logic [`BRIDGE_ADDR_W-1:0] addr,
                              input logic [`BRIDGE_LEN_W-1:0] len,
                              input axi_pkg::size_t size, input axi_pkg::burst_t burst);
        bit             accepted;
        int             cycles;
        int             n;
        axi_pkg::prot_t prot;
        accepted = 1'b0;
        cycles   = 0;
        // Each burst carries its own protection so a mix-up between bursts shows
        prot     = axi_pkg::prot_t'(id);
        if (!timed_out) begin
            exp_q.push_back('{id: id, addr: addr, len: len, size: size, burst: burst});
            for (n = 0; n <= int'(len); n++) begin
                prot_q.push_back(prot);
            end
            axi_ar_id    = id;
            axi_ar_addr  = addr;
            axi_ar_len   = len;
            axi_ar_size  = size;
            axi_ar_burst = burst;
            axi_ar_prot  = prot;
            axi_ar_valid = 1'b1;
            while (!accepted && !timed_out) begin
                @(negedge clk);
                if (axi_ar_ready) begin
                    accepted = 1'b1;
                end else if (++cycles >= 200) begin
                    timed_out = 1'b1;
                    $display("TIMEOUT test %s: burst with id %0h was never accepted",
                             test_name, id);
                end
            end
            if (accepted) begin
                @(posedge clk);
                #1;
                axi_ar_valid = 1'b0;
            end
        end
    endtask

    // Waits until all bursts of the test have returned, then reports the test
    task automatic end_test(input int exp_beats);
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && !timed_out) begin
            @(posedge clk);
            #1;
            if (++cycles >= 1000) begin
                timed_out = 1'b1;
                $display("TIMEOUT test %s: R beats still missing after %0d cycles",
                         test_name, cycles);
            end
        end
        check("beat count", 32'(exp_beats), 32'(beats_checked - beats_at_start));
        tests_run++;
        $display("test %-14s %0d beats, %0d errors", test_name,
                 beats_checked - beats_at_start, errors - errors_at_start);
    endtask

    initial begin : main
        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;

        start_test("single", 1'b0);
        send_burst(4'h3, 32'h0000_1040, 8'd0, 3'd2, axi_pkg::burst_incr);
        end_test(1);

        // Unaligned start where later beats land on aligned words
        start_test("incr_unaligned", 1'b0);
        send_burst(4'h5, 32'h0000_2106, 8'd7, 3'd2, axi_pkg::burst_incr);
        end_test(8);

        start_test("wrap", 1'b0);
        send_burst(4'h9, 32'h0000_3038, 8'd3, 3'd2, axi_pkg::burst_wrap);
        end_test(4);

        start_test("fixed", 1'b0);
        send_burst(4'h2, 32'h0000_4a10, 8'd3, 3'd2, axi_pkg::burst_fixed);
        end_test(4);

        // Crosses address bit 11, where the slave starts to answer with an error
        start_test("incr_slverr", 1'b0);
        send_burst(4'h6, 32'h0000_57f8, 8'd3, 3'd2, axi_pkg::burst_incr);
        end_test(4);

        start_test("back_to_back", 1'b1);
        send_burst(4'ha, 32'h6000_0100, 8'd5, 3'd2, axi_pkg::burst_incr);
        send_burst(4'hb, 32'h7000_0882, 8'd3, 3'd1, axi_pkg::burst_incr);
        end_test(10);

        $display("SUMMARY tests %0d, beats %0d, checks %0d, errors %0d",
                 tests_run, beats_checked, checks_done, errors);
        if (errors == 0 && !timed_out) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+hdl
hdl/axi_pkg.sv
hdl/bridge_pkg.sv
hdl/xact_if.sv
hdl/ar_splitter.sv
hdl/xact_queue.sv
hdl/r_tagger.sv
hdl/axi_rd_to_lite.sv
test/axi_rd_to_lite_chk.sv
test/tb_axi_rd_to_lite.sv

//--- run.sh
#!/bin/sh
# Compile the read bridge testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_axi_rd_to_lite
if [ $? -ne 0 ]; then
    echo "run.sh: Verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_axi_rd_to_lite > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "run.sh: simulation exited with status $status"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" sim.log; then
    exit 0
fi
echo "run.sh: pass message not found in sim.log"
exit 1
